//--- Makefile
SRCS := $(shell grep -v '^+' all.f) design/pin_bank_settings.svh

.PHONY: run clean

run: obj_dir/Vpin_bank_tb
	@out="$$(./obj_dir/Vpin_bank_tb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST RESULT: PASS$$'

obj_dir/V%: $(SRCS) all.f
	verilator --binary --timing --assert -f all.f --top-module $*

clean:
	rm -rf obj_dir

//--- all.f
+incdir+design
design/pin_bank_pkg.sv
design/bus_port.sv
design/pin_controller.sv
design/pin_bank_top.sv
tests/pin_bank_chk.sv
tests/pin_bank_tb.sv

//--- design/bus_port.sv
`default_nettype none

`include "pin_bank_settings.svh"

module bus_port
  import pin_bank_pkg::*;
(
  input  logic      sys_clk,
  input  logic      reset,
  input  logic      ebi_cs,
  input  logic      ebi_wr,
  input  logic      ebi_rd,
  input  bus_addr_t ebi_addr,
  input  bus_word_t bus_wdata,
  input  bus_word_t pin_rdata [`PB_NUM_PINS],
  output logic      wr_strobe,
  output logic      rd_strobe,
  output bus_addr_t addr,
  output bus_word_t wdata,
  output bus_word_t bus_rdata,
  output logic      bus_rdata_valid
);

  // bit 2 cs, bit 1 wr, bit 0 rd
  // active high after the inversion
  logic [2:0] sync_meta;
  logic [2:0] sync_q;

  logic wr_active;
  logic rd_active;
  logic wr_seen;
  logic rd_seen;
  logic wr_start;
  logic rd_start;

  // two-stage read in flight marker
  logic [1:0] rd_flight;
  bus_word_t  rdata_or;

  assign wr_active = sync_q[2] & sync_q[1];
  assign rd_active = sync_q[2] & sync_q[0];

  // first cycle of an access only
  // write wins if the host ever drives both
  assign wr_start = wr_active & ~wr_seen;
  assign rd_start = rd_active & ~rd_seen & ~wr_active;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      sync_meta <= '0;
      sync_q    <= '0;
      wr_seen   <= 1'b0;
      rd_seen   <= 1'b0;
      wr_strobe <= 1'b0;
      rd_strobe <= 1'b0;
      rd_flight <= '0;
    end else begin
      sync_meta <= ~{ebi_cs, ebi_wr, ebi_rd};
      sync_q    <= sync_meta;
      wr_seen   <= wr_active;
      rd_seen   <= rd_active;
      wr_strobe <= wr_start;
      rd_strobe <= rd_start;
      rd_flight <= {rd_flight[0], rd_strobe};
    end
  end

  // host holds address and data for the whole access
  always_ff @(posedge sys_clk) begin
    if (wr_start || rd_start) begin
      addr  <= ebi_addr;
      wdata <= bus_wdata;
    end
  end

  // unaddressed controllers return zero, so an or is enough
  always_comb begin
    rdata_or = '0;
    for (int i = 0; i < `PB_NUM_PINS; i++) begin
      rdata_or = rdata_or | pin_rdata[i];
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rd_flight[0]) begin
      bus_rdata <= rdata_or;
    end
  end

  assign bus_rdata_valid = rd_flight[1];

endmodule

`default_nettype wire

//--- design/pin_bank_pkg.sv
`default_nettype none

`include "pin_bank_settings.svh"

package pin_bank_pkg;

  // one word on the external data bus
  typedef logic [`PB_DATA_WIDTH-1:0] bus_word_t;

  // word address on the external bus
  typedef logic [`PB_ADDR_WIDTH-1:0] bus_addr_t;

  // pin drive modes
  typedef enum logic [1:0] {
    WAVE_OFF    = 2'd0,
    WAVE_HIGH   = 2'd1,
    WAVE_SQUARE = 2'd2,
    WAVE_PWM    = 2'd3
  } waveform_e;

  // register offsets inside one pin block
  // tick is read only
  typedef enum logic [1:0] {
    REG_WAVEFORM = 2'd0,
    REG_PERIOD   = 2'd1,
    REG_DUTY     = 2'd2,
    REG_TICK     = 2'd3
  } pin_reg_e;

endpackage

`default_nettype wire

//--- design/pin_bank_settings.svh
`ifndef PIN_BANK_SETTINGS_SVH
`define PIN_BANK_SETTINGS_SVH

// external memory bus
`define PB_DATA_WIDTH 16
`define PB_ADDR_WIDTH 19

// pin controller bank size
`define PB_NUM_PINS 8

// first register of pin 0, word address
`define PB_PIN_BASE 32

// words in each pin block
// waveform, period, duty, tick
`define PB_REGS_PER_PIN 4

`endif

//--- design/pin_bank_top.sv
`default_nettype none

`include "pin_bank_settings.svh"

module pin_bank_top
  import pin_bank_pkg::*;
(
  input  logic                    sys_clk,
  input  logic                    reset,
  input  logic                    ebi_cs,
  input  logic                    ebi_wr,
  input  logic                    ebi_rd,
  input  bus_addr_t               ebi_addr,
  input  bus_word_t               bus_wdata,
  output bus_word_t               bus_rdata,
  output logic                    bus_rdata_valid,
  output logic [`PB_NUM_PINS-1:0] pins
);

  // single-cycle strobes shared by every controller
  logic      wr_strobe;
  logic      rd_strobe;
  bus_addr_t addr;
  bus_word_t wdata;

  // one read word per controller, zero when not addressed
  bus_word_t pin_rdata [`PB_NUM_PINS];

  bus_port u_bus_port (
    .sys_clk         (sys_clk),
    .reset           (reset),
    .ebi_cs          (ebi_cs),
    .ebi_wr          (ebi_wr),
    .ebi_rd          (ebi_rd),
    .ebi_addr        (ebi_addr),
    .bus_wdata       (bus_wdata),
    .pin_rdata       (pin_rdata),
    .wr_strobe       (wr_strobe),
    .rd_strobe       (rd_strobe),
    .addr            (addr),
    .wdata           (wdata),
    .bus_rdata       (bus_rdata),
    .bus_rdata_valid (bus_rdata_valid)
  );

  // each controller decodes its own block from its index
  for (genvar i = 0; i < `PB_NUM_PINS; i++) begin : g_pin
    pin_controller #(
      .pin_index (i)
    ) u_pin_controller (
      .sys_clk   (sys_clk),
      .reset     (reset),
      .wr_strobe (wr_strobe),
      .rd_strobe (rd_strobe),
      .addr      (addr),
      .wdata     (wdata),
      .rdata     (pin_rdata[i]),
      .pin       (pins[i])
    );
  end

endmodule

`default_nettype wire

//--- design/pin_controller.sv
`default_nettype none

`include "pin_bank_settings.svh"

module pin_controller
  import pin_bank_pkg::*;
#(
  parameter int pin_index = 0
) (
  input  logic      sys_clk,
  input  logic      reset,
  input  logic      wr_strobe,
  input  logic      rd_strobe,
  input  bus_addr_t addr,
  input  bus_word_t wdata,
  output bus_word_t rdata,
  output logic      pin
);

  localparam int off_width = $clog2(`PB_REGS_PER_PIN);

  // this pin's register block
  localparam bus_addr_t block_base =
    bus_addr_t'(`PB_PIN_BASE + pin_index * `PB_REGS_PER_PIN);
  localparam bus_addr_t block_last =
    bus_addr_t'(`PB_PIN_BASE + pin_index * `PB_REGS_PER_PIN + `PB_REGS_PER_PIN - 1);

  logic      hit;
  bus_addr_t addr_off;
  pin_reg_e  reg_sel;
  logic      wr_accept;

  waveform_e wave_q;
  bus_word_t period_q;
  bus_word_t duty_q;
  bus_word_t tick_q;

  bus_word_t half_period;
  logic      level;
  bus_word_t read_word;

  assign hit      = (addr >= block_base) && (addr <= block_last);
  assign addr_off = addr - block_base;
  assign reg_sel  = pin_reg_e'(addr_off[off_width-1:0]);

  // writes to the read-only tick offset are dropped
  assign wr_accept = wr_strobe && hit && (reg_sel != REG_TICK);

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      wave_q   <= WAVE_OFF;
      period_q <= '0;
      duty_q   <= '0;
    end else if (wr_accept) begin
      case (reg_sel)
        REG_WAVEFORM: wave_q   <= waveform_e'(wdata[1:0]);
        REG_PERIOD:   period_q <= wdata;
        REG_DUTY:     duty_q   <= wdata;
        default: begin
        end
      endcase
    end
  end

  // tick counter restarts on any register change
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      tick_q <= '0;
    end else if (wr_accept) begin
      tick_q <= '0;
    end else if (period_q < bus_word_t'(2)) begin
      // period 0 or 1 holds the counter at zero
      tick_q <= '0;
    end else if (tick_q >= period_q - bus_word_t'(1)) begin
      tick_q <= '0;
    end else begin
      tick_q <= tick_q + bus_word_t'(1);
    end
  end

  assign half_period = period_q >> 1;

  always_comb begin
    case (wave_q)
      WAVE_OFF:    level = 1'b0;
      WAVE_HIGH:   level = 1'b1;
      WAVE_SQUARE: level = tick_q < half_period;
      WAVE_PWM:    level = tick_q < duty_q;
      default:     level = 1'b0;
    endcase
  end

  // pin lags the counter by one cycle
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      pin <= 1'b0;
    end else begin
      pin <= level;
    end
  end

  always_comb begin
    case (reg_sel)
      REG_WAVEFORM: read_word = bus_word_t'(wave_q);
      REG_PERIOD:   read_word = period_q;
      REG_DUTY:     read_word = duty_q;
      REG_TICK:     read_word = tick_q;
      default:      read_word = '0;
    endcase
  end

  // zero unless this block is addressed, so the bus port can or all pins
  always_ff @(posedge sys_clk) begin
    if (rd_strobe && hit) begin
      rdata <= read_word;
    end else begin
      rdata <= '0;
    end
  end

endmodule

`default_nettype wire

//--- tests/pin_bank_chk.sv
`default_nettype none

`include "pin_bank_settings.svh"

module pin_bank_chk (
  input logic                    sys_clk,
  input logic                    reset,
  input logic                    wr_strobe,
  input logic                    rd_strobe,
  input logic                    bus_rdata_valid,
  input logic [`PB_NUM_PINS-1:0] pins
);

  timeunit 1ns;
  timeprecision 1ps;

  // failure count per assertion
  int excl_fails = 0;
  int lag_fails = 0;
  int pulse_fails = 0;
  int flight_fails = 0;
  int reset_fails = 0;
  int fail_total;

  assign fail_total = excl_fails + lag_fails + pulse_fails + flight_fails + reset_fails;

  a_strobe_excl: assert property (@(posedge sys_clk) disable iff (reset)
    !(wr_strobe && rd_strobe))
    else begin
      excl_fails++;
      $error("write and read strobes high in the same cycle");
    end

  // valid exactly two cycles after the read strobe and never otherwise
  a_valid_lag: assert property (@(posedge sys_clk) disable iff (reset)
    bus_rdata_valid == $past(rd_strobe, 2))
    else begin
      lag_fails++;
      $error("read data valid does not follow the read strobe by two cycles");
    end

  a_valid_pulse: assert property (@(posedge sys_clk) disable iff (reset)
    !(bus_rdata_valid && $past(bus_rdata_valid)))
    else begin
      pulse_fails++;
      $error("read data valid high for two cycles in a row");
    end

  a_no_overlap: assert property (@(posedge sys_clk) disable iff (reset)
    (wr_strobe || rd_strobe) |-> !($past(rd_strobe) || $past(rd_strobe, 2)))
    else begin
      flight_fails++;
      $error("bus strobe while a read is still in flight");
    end

  a_reset_pins: assert property (@(posedge sys_clk)
    $fell(reset) |-> (pins == '0))
    else begin
      reset_fails++;
      $error("pins not low in the first cycle after reset");
    end

endmodule

bind pin_bank_top pin_bank_chk u_chk (
  .sys_clk         (sys_clk),
  .reset           (reset),
  .wr_strobe       (wr_strobe),
  .rd_strobe       (rd_strobe),
  .bus_rdata_valid (bus_rdata_valid),
  .pins            (pins)
);

`default_nettype wire

//--- tests/pin_bank_tb.sv
`default_nettype none

`include "pin_bank_settings.svh"

module pin_bank_tb
  import pin_bank_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_pins = `PB_NUM_PINS;
  localparam int n_readback = 24;
  localparam int n_pwm = 6;
  localparam int n_square = 6;
  localparam int n_tick = 8;
  localparam int max_period = 40;
  localparam int read_wait_limit = 20;

  // run limit from bus accesses and measured windows
  localparam int accesses = 32 + 2 * n_readback + 11 + num_pins + 3
                            + 4 * n_pwm + 3 * n_square + 2 * n_tick;
  localparam int windows = 20 + 100 + (n_pwm + n_square) * max_period + 20 * n_tick;
  localparam int cycle_limit = 2 * (40 * accesses + windows);

  logic                    sys_clk = 1'b0;
  logic                    reset;
  logic                    ebi_cs;
  logic                    ebi_wr;
  logic                    ebi_rd;
  bus_addr_t               ebi_addr;
  bus_word_t               bus_wdata;
  bus_word_t               bus_rdata;
  logic                    bus_rdata_valid;
  logic [`PB_NUM_PINS-1:0] pins;

  // shadow of what each pin was last told
  waveform_e shadow_wave [`PB_NUM_PINS];
  bus_word_t shadow_period [`PB_NUM_PINS];
  bus_word_t shadow_duty [`PB_NUM_PINS];

  int value_errors = 0;
  int other_errors = 0;
  int cycle_count = 0;

  pin_bank_top uut (
    .sys_clk         (sys_clk),
    .reset           (reset),
    .ebi_cs          (ebi_cs),
    .ebi_wr          (ebi_wr),
    .ebi_rd          (ebi_rd),
    .ebi_addr        (ebi_addr),
    .bus_wdata       (bus_wdata),
    .bus_rdata       (bus_rdata),
    .bus_rdata_valid (bus_rdata_valid),
    .pins            (pins)
  );

  always #2 sys_clk = ~sys_clk;

  function automatic bus_addr_t reg_addr(input int pin_num, input pin_reg_e r);
    return bus_addr_t'(`PB_PIN_BASE + pin_num * `PB_REGS_PER_PIN + int'(r));
  endfunction

  function automatic logic in_bank(input bus_addr_t a);
    return (a >= bus_addr_t'(`PB_PIN_BASE)) &&
           (a < bus_addr_t'(`PB_PIN_BASE + num_pins * `PB_REGS_PER_PIN));
  endfunction

  function automatic int pin_of(input bus_addr_t a);
    return int'(a - bus_addr_t'(`PB_PIN_BASE)) / `PB_REGS_PER_PIN;
  endfunction

  function automatic pin_reg_e reg_of(input bus_addr_t a);
    bus_addr_t rel;
    rel = a - bus_addr_t'(`PB_PIN_BASE);
    return pin_reg_e'(rel[1:0]);
  endfunction

  function automatic void model_write(input bus_addr_t a, input bus_word_t d);
    int p;
    if (in_bank(a)) begin
      p = pin_of(a);
      case (reg_of(a))
        REG_WAVEFORM: shadow_wave[p] = waveform_e'(d[1:0]);
        REG_PERIOD:   shadow_period[p] = d;
        REG_DUTY:     shadow_duty[p] = d;
        default:      ;
      endcase
    end
  endfunction

  // live tick is checked by range instead
  function automatic bus_word_t expected_word(input bus_addr_t a);
    bus_word_t result;
    int p;
    result = '0;
    if (in_bank(a)) begin
      p = pin_of(a);
      case (reg_of(a))
        REG_WAVEFORM: result = bus_word_t'(shadow_wave[p]);
        REG_PERIOD:   result = shadow_period[p];
        REG_DUTY:     result = shadow_duty[p];
        default:      result = '0;
      endcase
    end
    return result;
  endfunction

  // high cycles in any window one period long
  function automatic int expected_high_count(input waveform_e w, input bus_word_t period,
                                             input bus_word_t duty);
    case (w)
      WAVE_OFF:    return 0;
      WAVE_HIGH:   return int'(period);
      WAVE_SQUARE: return int'(period) / 2;
      default:     return (duty < period) ? int'(duty) : int'(period);
    endcase
  endfunction

  function automatic waveform_e parked_wave(input int p);
    return (p % 2 == 1) ? WAVE_HIGH : WAVE_OFF;
  endfunction

  function automatic logic [`PB_NUM_PINS-1:0] static_levels();
    logic [`PB_NUM_PINS-1:0] levels;
    for (int p = 0; p < num_pins; p++) begin
      levels[p] = (shadow_wave[p] == WAVE_HIGH);
    end
    return levels;
  endfunction

  task automatic check_word(input bus_word_t got, input bus_word_t exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR at %0t: %s returned 0x%04h, expected 0x%04h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      value_errors++;
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_below(input bus_word_t got, input bus_word_t limit, input string what);
    if (got >= limit) begin
      value_errors++;
      $display("ERROR at %0t: %s is %0d, expected below %0d", $time, what, got, limit);
    end
  endtask

  task automatic wait_cycle();
    @(posedge sys_clk);
    #1;
  endtask

  task automatic bus_write(input bus_addr_t a, input bus_word_t d);
    model_write(a, d);
    ebi_addr = a;
    bus_wdata = d;
    ebi_cs = 1'b0;
    ebi_wr = 1'b0;
    repeat (5) wait_cycle();
    ebi_cs = 1'b1;
    ebi_wr = 1'b1;
    repeat (4) wait_cycle();
  endtask

  task automatic bus_read(input bus_addr_t a, output bus_word_t data);
    int waited;
    logic got;
    waited = 0;
    got = 1'b0;
    data = '0;
    ebi_addr = a;
    ebi_cs = 1'b0;
    ebi_rd = 1'b0;
    while (!got && waited < read_wait_limit) begin
      wait_cycle();
      waited++;
      if (bus_rdata_valid) begin
        got = 1'b1;
        data = bus_rdata;
      end
    end
    if (!got) begin
      other_errors++;
      $display("read at address 0x%0h got no data valid pulse within %0d cycles",
               a, read_wait_limit);
    end
    ebi_cs = 1'b1;
    ebi_rd = 1'b1;
    repeat (4) wait_cycle();
  endtask

  // counts highs on one pin, and cycles where the parked pins drift
  task automatic count_high(input int p, input int cycles, output int highs,
                            output int others_bad);
    logic [`PB_NUM_PINS-1:0] mask;
    logic [`PB_NUM_PINS-1:0] want;
    mask = '1;
    mask[p] = 1'b0;
    want = static_levels();
    highs = 0;
    others_bad = 0;
    repeat (cycles) begin
      wait_cycle();
      if (pins[p]) highs++;
      if ((pins & mask) != (want & mask)) others_bad++;
    end
  endtask

  task automatic test_reset_state();
    int pin_highs;
    int valid_highs;
    bus_word_t rd;
    pin_highs = 0;
    valid_highs = 0;
    repeat (20) begin
      wait_cycle();
      if (pins != '0) pin_highs++;
      if (bus_rdata_valid) valid_highs++;
    end
    check_count(pin_highs, 0, "cycles with a pin high after reset");
    check_count(valid_highs, 0, "valid pulses with no read");
    for (int p = 0; p < num_pins; p++) begin
      for (int k = 0; k < `PB_REGS_PER_PIN; k++) begin
        bus_read(reg_addr(p, pin_reg_e'(2'(k))), rd);
        check_word(rd, '0, "register after reset");
      end
    end
  endtask

  task automatic test_readback();
    int p;
    logic [1:0] r_bits;
    bus_addr_t a;
    bus_word_t rd;
    bus_word_t tick_before;
    bus_addr_t unmapped [4];
    for (int i = 0; i < n_readback; i++) begin
      p = int'($urandom_range(num_pins - 1, 0));
      r_bits = 2'($urandom_range(2, 0));
      a = reg_addr(p, pin_reg_e'(r_bits));
      bus_write(a, bus_word_t'($urandom()));
      bus_read(a, rd);
      check_word(rd, expected_word(a), $sformatf("readback at 0x%0h", a));
    end
    // the tick offset takes no writes
    p = int'($urandom_range(num_pins - 1, 0));
    // a long period keeps the counter from wrapping
    bus_write(reg_addr(p, REG_PERIOD), 16'd1000);
    bus_read(reg_addr(p, REG_TICK), tick_before);
    bus_write(reg_addr(p, REG_TICK), 16'hbeef);
    bus_read(reg_addr(p, REG_TICK), rd);
    // a dropped write leaves the counter running
    check_below(tick_before, rd, "tick before the tick write");
    for (int k = 0; k < 3; k++) begin
      a = reg_addr(p, pin_reg_e'(2'(k)));
      bus_read(a, rd);
      check_word(rd, expected_word(a), $sformatf("register 0x%0h after tick write", a));
    end
    unmapped[0] = '0;
    unmapped[1] = bus_addr_t'(`PB_PIN_BASE - 1);
    unmapped[2] = bus_addr_t'(`PB_PIN_BASE + num_pins * `PB_REGS_PER_PIN);
    unmapped[3] = '1;
    foreach (unmapped[k]) begin
      bus_read(unmapped[k], rd);
      check_word(rd, expected_word(unmapped[k]), $sformatf("unmapped 0x%0h", unmapped[k]));
    end
  endtask

  // alternate low and high so every idle pin has a fixed level
  task automatic park_pins();
    for (int p = 0; p < num_pins; p++) begin
      bus_write(reg_addr(p, REG_WAVEFORM), bus_word_t'(parked_wave(p)));
    end
  endtask

  task automatic test_static();
    int p;
    int highs;
    int others_bad;
    p = int'($urandom_range(num_pins - 1, 0));
    bus_write(reg_addr(p, REG_WAVEFORM), bus_word_t'(WAVE_OFF));
    count_high(p, 50, highs, others_bad);
    check_count(highs, expected_high_count(WAVE_OFF, 16'd50, '0), "high cycles when off");
    check_count(others_bad, 0, "cycles with another pin off its level");
    bus_write(reg_addr(p, REG_WAVEFORM), bus_word_t'(WAVE_HIGH));
    count_high(p, 50, highs, others_bad);
    check_count(highs, expected_high_count(WAVE_HIGH, 16'd50, '0), "high cycles when high");
    check_count(others_bad, 0, "cycles with another pin off its level");
    bus_write(reg_addr(p, REG_WAVEFORM), bus_word_t'(parked_wave(p)));
  endtask

  task automatic test_periodic(input waveform_e w, input int runs);
    int p;
    int highs;
    int others_bad;
    bus_word_t per;
    for (int i = 0; i < runs; i++) begin
      p = int'($urandom_range(num_pins - 1, 0));
      per = bus_word_t'($urandom_range(max_period, 2));
      bus_write(reg_addr(p, REG_PERIOD), per);
      if (w == WAVE_PWM) begin
        bus_write(reg_addr(p, REG_DUTY), bus_word_t'($urandom_range(45, 0)));
      end
      bus_write(reg_addr(p, REG_WAVEFORM), bus_word_t'(w));
      count_high(p, int'(per), highs, others_bad);
      check_count(highs, expected_high_count(shadow_wave[p], shadow_period[p], shadow_duty[p]),
                  $sformatf("high cycles on pin %0d, period %0d", p, per));
      check_count(others_bad, 0, "cycles with another pin off its level");
      bus_write(reg_addr(p, REG_WAVEFORM), bus_word_t'(parked_wave(p)));
    end
  endtask

  task automatic test_live_tick();
    int p;
    bus_word_t rd;
    for (int i = 0; i < n_tick; i++) begin
      p = int'($urandom_range(num_pins - 1, 0));
      bus_write(reg_addr(p, REG_PERIOD), bus_word_t'($urandom_range(max_period, 0)));
      repeat ($urandom_range(20, 0)) wait_cycle();
      bus_read(reg_addr(p, REG_TICK), rd);
      if (shadow_period[p] < 16'd2) begin
        check_word(rd, '0, "tick with period below 2");
      end else begin
        check_below(rd, shadow_period[p], $sformatf("tick on pin %0d", p));
      end
    end
  endtask

  task automatic finish_run();
    int assert_fails;
    assert_fails = uut.u_chk.fail_total;
    if (assert_fails != 0) begin
      other_errors += assert_fails;
      $display("%0d checker assertions failed", assert_fails);
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  always @(posedge sys_clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      other_errors++;
      $display("simulation stopped after %0d cycles without finishing", cycle_count);
      finish_run();
    end
  end

  initial begin
    void'($urandom(32'h6a5e_290d));
    reset = 1'b1;
    ebi_cs = 1'b1;
    ebi_wr = 1'b1;
    ebi_rd = 1'b1;
    ebi_addr = '0;
    bus_wdata = '0;
    for (int p = 0; p < num_pins; p++) begin
      shadow_wave[p] = WAVE_OFF;
      shadow_period[p] = '0;
      shadow_duty[p] = '0;
    end
    repeat (10) @(posedge sys_clk);
    #1;
    reset = 1'b0;
    test_reset_state();
    test_readback();
    park_pins();
    test_static();
    test_periodic(WAVE_PWM, n_pwm);
    test_periodic(WAVE_SQUARE, n_square);
    test_live_tick();
    finish_run();
  end

endmodule

`default_nettype wire
